// ==== regs_macros.svh ====
// Widths, register map and timing constants; addresses are full byte addresses, compared exactly
`ifndef REGS_MACROS_SVH
`define REGS_MACROS_SVH

// Bus widths
`define REGS_ADDR_W 12
`define REGS_DATA_W 32
`define REGS_STRB_W (`REGS_DATA_W / 8)

// Register byte addresses
`define CSR_ADDR_ID      12'h000
`define CSR_ADDR_SCRATCH 12'h004
`define CSR_ADDR_CTRL    12'h008
`define CSR_ADDR_WRCNT   12'h00C

// Identity word contents
`define CSR_ID_VALUE 32'h5245_4701

// Write stall cycles after each write ack (at least 1)
`define CSR_WR_HOLDOFF 2

`endif

// ==== regs_pkg.sv ====
// Shared state and decode enums for the register subsystem; encodings are fixed widths, no import
package regs_pkg;

        // ==============================
        // Bridge command machine
        // ==============================
        typedef enum logic [1:0] {
                CMD_IDLE     = 2'b00,   // Free for a new command
                CMD_STALLED  = 2'b01,   // Command held, stall still high
                CMD_WAIT_ACK = 2'b10    // Request issued, ack due next cycle
        } cmd_state_t;

        // ==============================
        // Bridge response slot
        // ==============================
        typedef enum logic {
                RSP_EMPTY = 1'b0,       // Nothing pending
                RSP_VALID = 1'b1        // Held until rsp_ready
        } rsp_state_t;

        // ==============================
        // Register decode
        // ==============================
        typedef enum logic [2:0] {
                SEL_ID      = 3'd0,     // Read-only identity
                SEL_SCRATCH = 3'd1,
                SEL_CTRL    = 3'd2,
                SEL_WRCNT   = 3'd3,     // Read-only write count
                SEL_NONE    = 3'd4      // Unmapped, answers with error
        } csr_sel_t;

endpackage

// ==== cmdrsp_regblk_bridge.sv ====
// Single outstanding command only; regblk must ack exactly one cycle after each req pulse
`timescale 1ns/1ps
`include "regs_macros.svh"

module cmdrsp_regblk_bridge (
        input  logic                      aclk,
        input  logic                      rst,
        // Command channel
        input  logic                      cmd_valid,
        output logic                      cmd_ready,
        input  logic                      cmd_pwrite,           // 1 = write
        input  logic [`REGS_ADDR_W-1:0]   cmd_paddr,
        input  logic [`REGS_DATA_W-1:0]   cmd_pwdata,
        input  logic [`REGS_STRB_W-1:0]   cmd_pstrb,
        // Response channel
        output logic                      rsp_valid,
        input  logic                      rsp_ready,
        output logic [`REGS_DATA_W-1:0]   rsp_prdata,           // Zero for writes
        output logic                      rsp_pslverr,
        // Register block side
        output logic                      regblk_req,           // One-cycle pulse
        output logic                      regblk_req_is_wr,
        output logic [`REGS_ADDR_W-1:0]   regblk_addr,
        output logic [`REGS_DATA_W-1:0]   regblk_wr_data,
        output logic [`REGS_DATA_W-1:0]   regblk_wr_biten,
        input  logic                      regblk_req_stall_wr,
        input  logic                      regblk_req_stall_rd,
        input  logic                      regblk_rd_ack,
        input  logic                      regblk_rd_err,
        input  logic [`REGS_DATA_W-1:0]   regblk_rd_data,
        input  logic                      regblk_wr_ack,
        input  logic                      regblk_wr_err
);

        regs_pkg::cmd_state_t cmd_state, cmd_state_next;
        regs_pkg::rsp_state_t rsp_state;

        // Parked command payload
        logic                      held_pwrite;
        logic [`REGS_ADDR_W-1:0]   held_paddr;
        logic [`REGS_DATA_W-1:0]   held_pwdata;
        logic [`REGS_STRB_W-1:0]   held_pstrb;

        logic cmd_fire;
        logic live_stall;   // Stall for the incoming command kind
        logic held_stall;   // Stall for the parked command kind
        logic any_ack;
        logic use_live;

        // Byte strobes to bit enables
        function automatic logic [`REGS_DATA_W-1:0] strb_to_biten(
                input logic [`REGS_STRB_W-1:0] strb
        );
                logic [`REGS_DATA_W-1:0] biten;
                for (int i = 0; i < `REGS_STRB_W; i++) begin
                        biten[i*8 +: 8] = {8{strb[i]}};
                end
                return biten;
        endfunction

        // ==============================
        // Command machine
        // ==============================
        assign cmd_ready  = (cmd_state == regs_pkg::CMD_IDLE) &&
                            (rsp_state == regs_pkg::RSP_EMPTY);  // Slot must be free too
        assign cmd_fire   = cmd_valid && cmd_ready;
        assign live_stall = cmd_pwrite  ? regblk_req_stall_wr : regblk_req_stall_rd;
        assign held_stall = held_pwrite ? regblk_req_stall_wr : regblk_req_stall_rd;
        assign any_ack    = regblk_rd_ack || regblk_wr_ack;

        always_comb begin
                cmd_state_next = cmd_state;
                regblk_req     = 1'b0;
                case (cmd_state)
                        regs_pkg::CMD_IDLE: begin
                                if (cmd_fire) begin
                                        if (!live_stall) begin
                                                regblk_req     = 1'b1;  // Handshake cycle is req cycle
                                                cmd_state_next = regs_pkg::CMD_WAIT_ACK;
                                        end else begin
                                                cmd_state_next = regs_pkg::CMD_STALLED;
                                        end
                                end
                        end
                        regs_pkg::CMD_STALLED: begin
                                if (!held_stall) begin  // First free cycle
                                        regblk_req     = 1'b1;
                                        cmd_state_next = regs_pkg::CMD_WAIT_ACK;
                                end
                        end
                        regs_pkg::CMD_WAIT_ACK: begin
                                if (any_ack) cmd_state_next = regs_pkg::CMD_IDLE;
                        end
                        default: cmd_state_next = regs_pkg::CMD_IDLE;
                endcase
        end

        always_ff @(posedge aclk) begin
                if (rst) cmd_state <= regs_pkg::CMD_IDLE;
                else     cmd_state <= cmd_state_next;
        end

        always_ff @(posedge aclk) begin
                if (cmd_fire) begin
                        held_pwrite <= cmd_pwrite;
                        held_paddr  <= cmd_paddr;
                        held_pwdata <= cmd_pwdata;
                        held_pstrb  <= cmd_pstrb;
                end
        end

        // Live payload in idle, parked payload afterwards
        assign use_live         = (cmd_state == regs_pkg::CMD_IDLE);
        assign regblk_req_is_wr = use_live ? cmd_pwrite : held_pwrite;
        assign regblk_addr      = use_live ? cmd_paddr  : held_paddr;
        assign regblk_wr_data   = use_live ? cmd_pwdata : held_pwdata;
        assign regblk_wr_biten  = strb_to_biten(use_live ? cmd_pstrb : held_pstrb);

        // ==============================
        // Response slot
        // ==============================
        always_ff @(posedge aclk) begin
                if (rst) begin
                        rsp_state <= regs_pkg::RSP_EMPTY;
                end else if (rsp_state == regs_pkg::RSP_EMPTY) begin
                        if (any_ack) rsp_state <= regs_pkg::RSP_VALID;
                end else if (rsp_ready) begin
                        rsp_state <= regs_pkg::RSP_EMPTY;
                end
        end

        always_ff @(posedge aclk) begin
                if (any_ack) begin
                        rsp_prdata  <= regblk_rd_ack ? regblk_rd_data : '0;
                        rsp_pslverr <= regblk_rd_ack ? regblk_rd_err  : regblk_wr_err;
                end
        end

        assign rsp_valid = (rsp_state == regs_pkg::RSP_VALID);

        // ==============================
        // Checks
        // ==============================
        a_cmd_hold: assert property (@(posedge aclk) disable iff (rst)
                (cmd_valid && !cmd_ready) |=> cmd_valid && $stable(cmd_pwrite) &&
                $stable(cmd_paddr) && $stable(cmd_pwdata) && $stable(cmd_pstrb))
                else $error("command payload changed before cmd_ready");

        a_rsp_hold: assert property (@(posedge aclk) disable iff (rst)
                (rsp_valid && !rsp_ready) |=> rsp_valid && $stable(rsp_prdata) &&
                $stable(rsp_pslverr))
                else $error("response changed under back-pressure");

        // Ack only where one is owed, else it would be lost
        a_ack_owed: assert property (@(posedge aclk) disable iff (rst)
                any_ack |-> (cmd_state == regs_pkg::CMD_WAIT_ACK))
                else $error("acknowledge outside wait-ack");

endmodule

// ==== csr_block.sv ====
// Four-word register file; unlisted or misaligned addresses unmapped, errored writes are dropped
`timescale 1ns/1ps
`include "regs_macros.svh"

module csr_block (
        input  logic                      aclk,
        input  logic                      rst,
        // Request side
        input  logic                      regblk_req,
        input  logic                      regblk_req_is_wr,
        input  logic [`REGS_ADDR_W-1:0]   regblk_addr,
        input  logic [`REGS_DATA_W-1:0]   regblk_wr_data,
        input  logic [`REGS_DATA_W-1:0]   regblk_wr_biten,
        output logic                      regblk_req_stall_wr,
        output logic                      regblk_req_stall_rd,
        // Acknowledges due one cycle after req
        output logic                      regblk_rd_ack,
        output logic                      regblk_rd_err,
        output logic [`REGS_DATA_W-1:0]   regblk_rd_data,
        output logic                      regblk_wr_ack,
        output logic                      regblk_wr_err,
        // Misc
        input  logic                      csr_lock,             // Blocks reads while high
        output logic [`REGS_DATA_W-1:0]   ctrl_word
);

        localparam int HOLD_W = $clog2(`CSR_WR_HOLDOFF + 1);

        regs_pkg::csr_sel_t sel;

        logic [`REGS_DATA_W-1:0] scratch_q;
        logic [`REGS_DATA_W-1:0] ctrl_q;
        logic [`REGS_DATA_W-1:0] wrcnt_q;
        logic [`REGS_DATA_W-1:0] rd_mux;
        logic [HOLD_W-1:0]       holdoff_cnt;
        logic                    writable;
        logic                    wr_ok;
        logic                    wr_bad;
        logic                    rd_bad;

        // ==============================
        // Address decode
        // ==============================
        always_comb begin
                case (regblk_addr)
                        `CSR_ADDR_ID:      sel = regs_pkg::SEL_ID;
                        `CSR_ADDR_SCRATCH: sel = regs_pkg::SEL_SCRATCH;
                        `CSR_ADDR_CTRL:    sel = regs_pkg::SEL_CTRL;
                        `CSR_ADDR_WRCNT:   sel = regs_pkg::SEL_WRCNT;
                        default:           sel = regs_pkg::SEL_NONE;
                endcase
        end

        assign writable = (sel == regs_pkg::SEL_SCRATCH) || (sel == regs_pkg::SEL_CTRL);
        assign wr_ok    = regblk_req && regblk_req_is_wr && writable;
        assign wr_bad   = !writable;                   // ID, WRCNT and unmapped
        assign rd_bad   = (sel == regs_pkg::SEL_NONE);

        always_comb begin
                case (sel)
                        regs_pkg::SEL_ID:      rd_mux = `CSR_ID_VALUE;
                        regs_pkg::SEL_SCRATCH: rd_mux = scratch_q;
                        regs_pkg::SEL_CTRL:    rd_mux = ctrl_q;
                        regs_pkg::SEL_WRCNT:   rd_mux = wrcnt_q;
                        default:               rd_mux = '0;  // Unmapped reads as zero
                endcase
        end

        // ==============================
        // Register storage
        // ==============================
        always_ff @(posedge aclk) begin
                if (rst) begin
                        scratch_q <= '0;
                        ctrl_q    <= '0;
                        wrcnt_q   <= '0;
                end else if (wr_ok) begin
                        if (sel == regs_pkg::SEL_SCRATCH)
                                scratch_q <= (scratch_q & ~regblk_wr_biten) |
                                             (regblk_wr_data & regblk_wr_biten);
                        if (sel == regs_pkg::SEL_CTRL)
                                ctrl_q <= (ctrl_q & ~regblk_wr_biten) |
                                          (regblk_wr_data & regblk_wr_biten);
                        wrcnt_q <= wrcnt_q + `REGS_DATA_W'(1);  // Successful writes only
                end
        end

        assign ctrl_word = ctrl_q;

        // ==============================
        // Acknowledge path
        // ==============================
        always_ff @(posedge aclk) begin
                if (rst) begin
                        regblk_rd_ack <= 1'b0;
                        regblk_wr_ack <= 1'b0;
                        regblk_rd_err <= 1'b0;
                        regblk_wr_err <= 1'b0;
                end else begin
                        regblk_rd_ack <= regblk_req && !regblk_req_is_wr;
                        regblk_wr_ack <= regblk_req &&  regblk_req_is_wr;
                        regblk_rd_err <= regblk_req && !regblk_req_is_wr && rd_bad;
                        regblk_wr_err <= regblk_req &&  regblk_req_is_wr && wr_bad;
                end
        end

        // Read data sampled with the read request
        always_ff @(posedge aclk) begin
                if (regblk_req && !regblk_req_is_wr) regblk_rd_data <= rd_mux;
        end

        // ==============================
        // Stall generation
        // ==============================
        always_ff @(posedge aclk) begin
                if (rst) begin
                        holdoff_cnt <= '0;
                end else if (regblk_wr_ack) begin
                        holdoff_cnt <= HOLD_W'(`CSR_WR_HOLDOFF);  // Restart hold-off
                end else if (holdoff_cnt != '0) begin
                        holdoff_cnt <= holdoff_cnt - HOLD_W'(1);
                end
        end

        assign regblk_req_stall_wr = (holdoff_cnt != '0);
        assign regblk_req_stall_rd = csr_lock;

        // Bridge must honour stall of its own kind
        a_no_req_in_stall: assert property (@(posedge aclk) disable iff (rst)
                regblk_req |-> !(regblk_req_is_wr ? regblk_req_stall_wr : regblk_req_stall_rd))
                else $error("request issued while stalled");

        // No new req in the cycle its predecessor is acked
        a_ack_not_overlapped: assert property (@(posedge aclk) disable iff (rst)
                regblk_req |=> !regblk_req)
                else $error("request issued while the previous acknowledge was due");

endmodule

// ==== regs_subsys_top.sv ====
// Bridge plus register file; one command in flight, ctrl_word follows the control register
`timescale 1ns/1ps
`include "regs_macros.svh"

module regs_subsys_top (
        input  logic                      aclk,
        input  logic                      rst,
        // Command channel
        input  logic                      cmd_valid,
        output logic                      cmd_ready,
        input  logic                      cmd_pwrite,
        input  logic [`REGS_ADDR_W-1:0]   cmd_paddr,
        input  logic [`REGS_DATA_W-1:0]   cmd_pwdata,
        input  logic [`REGS_STRB_W-1:0]   cmd_pstrb,
        // Response channel
        output logic                      rsp_valid,
        input  logic                      rsp_ready,
        output logic [`REGS_DATA_W-1:0]   rsp_prdata,
        output logic                      rsp_pslverr,
        // Side band
        input  logic                      csr_lock,
        output logic [`REGS_DATA_W-1:0]   ctrl_word
);

        // ==============================
        // Bridge to register block
        // ==============================
        logic                    regblk_req;
        logic                    regblk_req_is_wr;
        logic [`REGS_ADDR_W-1:0] regblk_addr;
        logic [`REGS_DATA_W-1:0] regblk_wr_data;
        logic [`REGS_DATA_W-1:0] regblk_wr_biten;
        logic                    regblk_req_stall_wr;
        logic                    regblk_req_stall_rd;
        logic                    regblk_rd_ack;
        logic                    regblk_rd_err;
        logic [`REGS_DATA_W-1:0] regblk_rd_data;
        logic                    regblk_wr_ack;
        logic                    regblk_wr_err;

        cmdrsp_regblk_bridge u_bridge (
                .aclk, .rst,
                .cmd_valid, .cmd_ready, .cmd_pwrite, .cmd_paddr, .cmd_pwdata, .cmd_pstrb,
                .rsp_valid, .rsp_ready, .rsp_prdata, .rsp_pslverr,
                .regblk_req, .regblk_req_is_wr, .regblk_addr, .regblk_wr_data,
                .regblk_wr_biten, .regblk_req_stall_wr, .regblk_req_stall_rd,
                .regblk_rd_ack, .regblk_rd_err, .regblk_rd_data,
                .regblk_wr_ack, .regblk_wr_err
        );

        csr_block u_csr (
                .aclk, .rst,
                .regblk_req, .regblk_req_is_wr, .regblk_addr, .regblk_wr_data,
                .regblk_wr_biten, .regblk_req_stall_wr, .regblk_req_stall_rd,
                .regblk_rd_ack, .regblk_rd_err, .regblk_rd_data,
                .regblk_wr_ack, .regblk_wr_err,
                .csr_lock, .ctrl_word
        );

endmodule

// ==== tb_regs_subsys.sv ====
// One command in flight; expected values from a register shadow, rsp_ready high outside back-pressure
`timescale 1ns/1ps
`include "regs_macros.svh"

module tb_regs_subsys;

        localparam int ADDR_W   = `REGS_ADDR_W;
        localparam int DATA_W   = `REGS_DATA_W;
        localparam int STRB_W   = `REGS_STRB_W;
        localparam int N_RANDOM = 12;   // Write/read pairs
        localparam int N_BURST  = 6;    // Back-to-back writes
        localparam int N_BP     = 16;   // Commands under back-pressure
        localparam int NUM_CMDS = 18 + 2*N_RANDOM + N_BURST + N_BP;
        localparam int LIMIT    = 40*NUM_CMDS + 200;

        logic              aclk, rst;
        logic              cmd_valid, cmd_ready, cmd_pwrite;
        logic [ADDR_W-1:0] cmd_paddr;
        logic [DATA_W-1:0] cmd_pwdata;
        logic [STRB_W-1:0] cmd_pstrb;
        logic              rsp_valid, rsp_ready, rsp_pslverr;
        logic [DATA_W-1:0] rsp_prdata;
        logic              csr_lock;
        logic [DATA_W-1:0] ctrl_word;

        int errors   = 0;
        int cycle    = 0;
        int hs_cycle = 0;       // Cycle of the last command handshake
        bit bp_mode  = 1'b0;    // Random rsp_ready gaps

        // Register shadow
        logic [DATA_W-1:0] sh_scratch, sh_ctrl, sh_wrcnt;

        regs_subsys_top dut (.*);

        always #2 aclk = ~aclk;

        // ==============================
        // Timeout and checks
        // ==============================
        always @(posedge aclk) begin
                cycle++;
                if (cycle >= LIMIT) begin
                        $display("Timeout: run did not finish within %0d cycles", LIMIT);
                        $display("sim failed");
                        $finish;
                end
        end

        task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
                assert (act === exp) else begin
                        errors++;
                        $display("Fail at time %0t: %s expected %h got %h", $time, name, exp, act);
                end
        endtask

        task automatic check_bit(input string name, input logic exp, input logic act);
                assert (act === exp) else begin
                        errors++;
                        $display("Fail at time %0t: %s expected %b got %b", $time, name, exp, act);
                end
        endtask

        // Slot full means no new command
        a_ready_blocked: assert property (@(posedge aclk) disable iff (rst)
                rsp_valid |-> !cmd_ready)
                else begin
                        errors++;
                        $display("cmd_ready was high at time %0t while a response was pending",
                                 $time);
                end

        // Response stability under back-pressure
        logic              hold_prev;
        logic [DATA_W-1:0] prdata_prev;
        logic              err_prev;
        always @(negedge aclk) begin
                if (!rst && hold_prev) begin
                        check_bit("rsp_valid", 1'b1, rsp_valid);
                        check_val("rsp_prdata", prdata_prev, rsp_prdata);
                        check_bit("rsp_pslverr", err_prev, rsp_pslverr);
                end
                hold_prev   = rsp_valid && !rsp_ready;
                prdata_prev = rsp_prdata;
                err_prev    = rsp_pslverr;
        end

        // ==============================
        // Shadow model
        // ==============================
        function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
                case (addr)
                        `CSR_ADDR_ID:      return `CSR_ID_VALUE;
                        `CSR_ADDR_SCRATCH: return sh_scratch;
                        `CSR_ADDR_CTRL:    return sh_ctrl;
                        `CSR_ADDR_WRCNT:   return sh_wrcnt;
                        default:           return '0;
                endcase
        endfunction

        function automatic logic model_err(input logic wr, input logic [ADDR_W-1:0] addr);
                if (wr)
                        return !(addr == `CSR_ADDR_SCRATCH || addr == `CSR_ADDR_CTRL);
                return !(addr == `CSR_ADDR_ID || addr == `CSR_ADDR_SCRATCH ||
                         addr == `CSR_ADDR_CTRL || addr == `CSR_ADDR_WRCNT);
        endfunction

        task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                   input logic [STRB_W-1:0] strb);
                for (int i = 0; i < STRB_W; i++) begin
                        if (strb[i] && addr == `CSR_ADDR_SCRATCH)
                                sh_scratch[i*8 +: 8] = data[i*8 +: 8];
                        if (strb[i] && addr == `CSR_ADDR_CTRL)
                                sh_ctrl[i*8 +: 8] = data[i*8 +: 8];
                end
                sh_wrcnt++;     // Counts even with no strobe set
        endtask

        function automatic logic [ADDR_W-1:0] pick_unmapped();
                logic [ADDR_W-1:0] a;
                a = ADDR_W'($urandom);
                while (!model_err(1'b0, a)) a = ADDR_W'($urandom);
                return a;
        endfunction

        function automatic logic [ADDR_W-1:0] pick_addr();
                case ($urandom % 5)
                        0:       return `CSR_ADDR_ID;
                        1:       return `CSR_ADDR_SCRATCH;
                        2:       return `CSR_ADDR_CTRL;
                        3:       return `CSR_ADDR_WRCNT;
                        default: return pick_unmapped();
                endcase
        endfunction

        // ==============================
        // Channel drivers
        // ==============================
        task automatic send_cmd(input logic wr, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
                logic ready_seen;
                ready_seen = 1'b0;
                cmd_valid  = 1'b1;
                cmd_pwrite = wr;
                cmd_paddr  = addr;
                cmd_pwdata = data;
                cmd_pstrb  = strb;
                while (!ready_seen) begin
                        @(negedge aclk);
                        ready_seen = cmd_ready;         // Stable between edges
                        hs_cycle   = cycle;
                        @(posedge aclk);
                        #1;
                end
                cmd_valid = 1'b0;
        endtask

        task automatic wait_rsp(output logic [DATA_W-1:0] data, output logic err, output int lat);
                logic got;
                got = 1'b0;
                lat = -1;
                while (!got) begin
                        @(negedge aclk);
                        if (rsp_valid && lat < 0) lat = cycle - hs_cycle;
                        got  = rsp_valid && rsp_ready;
                        data = rsp_prdata;
                        err  = rsp_pslverr;
                        @(posedge aclk);
                        #1;
                        rsp_ready = bp_mode ? (($urandom % 2) != 0) : 1'b1;
                end
        endtask

        // Full command with response and shadow checks
        task automatic access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                              input bit fast);
                logic [DATA_W-1:0] got_data, exp_data;
                logic              got_err, exp_err;
                int                lat;
                exp_err  = model_err(wr, addr);
                exp_data = wr ? '0 : model_read(addr);  // Writes answer with zero
                send_cmd(wr, addr, data, strb);
                wait_rsp(got_data, got_err, lat);
                check_bit("rsp_pslverr", exp_err, got_err);
                check_val("rsp_prdata", exp_data, got_data);
                if (fast) check_val("rsp_valid latency", 32'd2, 32'(lat));
                if (wr && !exp_err) model_write(addr, data, strb);
                check_val("ctrl_word", sh_ctrl, ctrl_word);
        endtask

        // ==============================
        // Test sequence
        // ==============================
        initial begin
                logic [ADDR_W-1:0] addr;
                logic [DATA_W-1:0] rdata;
                logic              rerr;
                int                lat;
                void'($urandom(32'h2493_56b5));
                aclk = 1'b0;
                rst  = 1'b1;
                cmd_valid  = 1'b0;
                cmd_pwrite = 1'b0;
                cmd_paddr  = '0;
                cmd_pwdata = '0;
                cmd_pstrb  = '0;
                rsp_ready  = 1'b1;
                csr_lock   = 1'b0;
                sh_scratch = '0;
                sh_ctrl    = '0;
                sh_wrcnt   = '0;
                repeat (16) @(posedge aclk);
                #1 rst = 1'b0;

                // Reset state and first reads
                @(negedge aclk);
                check_bit("cmd_ready", 1'b1, cmd_ready);
                check_bit("rsp_valid", 1'b0, rsp_valid);
                @(posedge aclk);
                #1;
                access(1'b0, `CSR_ADDR_ID, '0, '0, 1'b1);
                access(1'b0, `CSR_ADDR_SCRATCH, '0, '0, 1'b1);
                access(1'b0, `CSR_ADDR_CTRL, '0, '0, 1'b1);
                access(1'b0, `CSR_ADDR_WRCNT, '0, '0, 1'b1);

                // Strobed writes each followed by an unstalled readback
                for (int i = 0; i < N_RANDOM; i++) begin
                        addr = (($urandom % 2) != 0) ? `CSR_ADDR_SCRATCH : `CSR_ADDR_CTRL;
                        access(1'b1, addr, $urandom, STRB_W'($urandom), 1'b0);
                        access(1'b0, addr, '0, '0, 1'b1);
                end

                // Idle past the hold-off, then an unstalled write
                repeat (4) @(posedge aclk);
                #1;
                access(1'b1, `CSR_ADDR_CTRL, $urandom, '1, 1'b1);

                // Error cases
                access(1'b0, pick_unmapped(), '0, '0, 1'b1);
                access(1'b1, pick_unmapped(), $urandom, '1, 1'b0);
                access(1'b1, `CSR_ADDR_ID, $urandom, '1, 1'b0);
                access(1'b1, `CSR_ADDR_WRCNT, $urandom, '1, 1'b0);
                access(1'b1, 12'h006, $urandom, '1, 1'b0);     // Misaligned
                access(1'b0, `CSR_ADDR_ID, '0, '0, 1'b1);
                access(1'b0, `CSR_ADDR_SCRATCH, '0, '0, 1'b1);
                access(1'b0, `CSR_ADDR_WRCNT, '0, '0, 1'b1);

                // Reads held off by csr_lock
                for (int n = 0; n < 2; n++) begin
                        csr_lock = 1'b1;
                        addr = (n == 0) ? `CSR_ADDR_SCRATCH : `CSR_ADDR_WRCNT;
                        send_cmd(1'b0, addr, '0, '0);
                        repeat (3 + $urandom % 5) begin
                                @(negedge aclk);
                                check_bit("rsp_valid", 1'b0, rsp_valid);
                                @(posedge aclk);
                        end
                        #1 csr_lock = 1'b0;
                        wait_rsp(rdata, rerr, lat);
                        check_bit("rsp_pslverr", 1'b0, rerr);
                        check_val("rsp_prdata", model_read(addr), rdata);
                end

                // Back-to-back writes through the write hold-off
                for (int i = 0; i < N_BURST; i++)
                        access(1'b1, `CSR_ADDR_SCRATCH, $urandom, STRB_W'($urandom), 1'b0);
                access(1'b0, `CSR_ADDR_SCRATCH, '0, '0, 1'b1);
                access(1'b0, `CSR_ADDR_WRCNT, '0, '0, 1'b1);

                // Random mix under response back-pressure
                bp_mode   = 1'b1;
                rsp_ready = 1'b0;
                for (int i = 0; i < N_BP; i++)
                        access(($urandom % 2) != 0, pick_addr(), $urandom,
                               STRB_W'($urandom), 1'b0);
                bp_mode   = 1'b0;
                rsp_ready = 1'b1;
                access(1'b0, `CSR_ADDR_WRCNT, '0, '0, 1'b1);

                $display("Checks finished with %0d errors", errors);
                if (errors == 0)
                        $display("sim passed");
                else
                        $display("sim failed");
                $finish;
        end

endmodule

// ==== filelist.f ====
+incdir+.
regs_pkg.sv
cmdrsp_regblk_bridge.sv
csr_block.sv
regs_subsys_top.sv
tb_regs_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_regs_subsys \
        && ./obj_dir/Vtb_regs_subsys > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
